// File: hdl/id_pkg.sv
`default_nettype none

package id_pkg;

    localparam int isa_width          = 32;       // instruction and data word
    localparam int reg_addr_width     = 5;        // register index bits
    localparam int shift_amount_width = 5;        // shamt field
    localparam int address_width      = 26;       // j / jal target field
    localparam int jal_reg_idx        = 31;       // link register

    typedef logic [reg_addr_width-1:0] reg_idx_t;

    // primary opcode, instruction[31:26]
    typedef enum logic [5:0] {
        op_rtype = 6'h00,                         // funct selects the operation
        op_j     = 6'h02,
        op_jal   = 6'h03,
        op_beq   = 6'h04,
        op_bne   = 6'h05,                         // bit 0 set marks bne
        op_addi  = 6'h08,
        op_slti  = 6'h0a,
        op_andi  = 6'h0c,
        op_ori   = 6'h0d,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_e;

    // r type function field, instruction[5:0]
    typedef enum logic [5:0] {
        fn_sll = 6'h00,
        fn_srl = 6'h02,
        fn_jr  = 6'h08,
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_slt = 6'h2a
    } funct_e;

    // operation handed to execute
    typedef enum logic [3:0] {
        alu_nop = 4'd0,                           // bubble, unknown, j and jr
        alu_add = 4'd1,
        alu_sub = 4'd2,
        alu_and = 4'd3,
        alu_or  = 4'd4,
        alu_slt = 4'd5,
        alu_sll = 4'd6,
        alu_srl = 4'd7
    } alu_op_e;

endpackage

`default_nettype wire

// File: hdl/id_ctrl_if.sv
`default_nettype none

interface id_ctrl_if import id_pkg::*; ();

    logic    i_type_instruction;                  // addi slti andi ori lw sw
    logic    r_type_instruction;                  // op_rtype except jr
    logic    j_instruction;                       // plain j only
    logic    jr_instruction;
    logic    jal_instruction;
    logic    branch_instruction;                  // beq or bne
    logic    shift_instruction;                   // sll or srl
    alu_op_e alu_op;

    modport decoder (
        output i_type_instruction, r_type_instruction, j_instruction, jr_instruction,
               jal_instruction, branch_instruction, shift_instruction, alu_op
    );

    modport mux (
        input  i_type_instruction, r_type_instruction, j_instruction, jr_instruction,
               jal_instruction, branch_instruction, shift_instruction, alu_op
    );

endinterface

`default_nettype wire

// File: hdl/id_operand_if.sv
`default_nettype none

interface id_operand_if import id_pkg::*; ();

    logic [isa_width-1:0] reg_1;                  // rs value after bypass
    logic [isa_width-1:0] reg_2;                  // rt value after bypass
    logic [isa_width-1:0] sign_extend_result;     // immediate widened to a word
    logic                 condition_satisfied;    // beq / bne outcome

    modport fetch (
        output reg_1, reg_2, sign_extend_result, condition_satisfied
    );

    modport mux (
        input  reg_1, reg_2, sign_extend_result, condition_satisfied
    );

endinterface

`default_nettype wire

// File: hdl/control_unit.sv
`default_nettype none

module control_unit import id_pkg::*; (
    input  opcode_e    opcode,                    // instruction[31:26]
    input  funct_e     funct,                     // instruction[5:0], r type only
    id_ctrl_if.decoder ctrl                       // class flags and alu operation
);

    always_comb begin
        ctrl.i_type_instruction = 1'b0;           // unknown encodings leave all flags low
        ctrl.r_type_instruction = 1'b0;
        ctrl.j_instruction      = 1'b0;
        ctrl.jr_instruction     = 1'b0;
        ctrl.jal_instruction    = 1'b0;
        ctrl.branch_instruction = 1'b0;
        ctrl.shift_instruction  = 1'b0;
        ctrl.alu_op             = alu_nop;

        case (opcode)
            op_rtype: begin
                case (funct)
                    fn_add: ctrl.alu_op = alu_add;
                    fn_sub: ctrl.alu_op = alu_sub;
                    fn_and: ctrl.alu_op = alu_and;
                    fn_or:  ctrl.alu_op = alu_or;
                    fn_slt: ctrl.alu_op = alu_slt;
                    fn_sll: ctrl.alu_op = alu_sll;
                    fn_srl: ctrl.alu_op = alu_srl;
                    fn_jr:  ctrl.jr_instruction = 1'b1;      // redirect only, no alu work
                    default: ;                               // illegal funct is a bubble
                endcase
                ctrl.r_type_instruction = (ctrl.alu_op != alu_nop);  // every legal funct but jr
                ctrl.shift_instruction  = (funct == fn_sll) || (funct == fn_srl);
            end
            op_addi, op_lw, op_sw: begin
                ctrl.i_type_instruction = 1'b1;
                ctrl.alu_op             = alu_add;           // address or sum
            end
            op_slti: begin
                ctrl.i_type_instruction = 1'b1;
                ctrl.alu_op             = alu_slt;
            end
            op_andi: begin
                ctrl.i_type_instruction = 1'b1;
                ctrl.alu_op             = alu_and;
            end
            op_ori: begin
                ctrl.i_type_instruction = 1'b1;
                ctrl.alu_op             = alu_or;
            end
            op_beq, op_bne: begin
                ctrl.branch_instruction = 1'b1;
                ctrl.alu_op             = alu_sub;           // compare by subtraction
            end
            op_j: begin
                ctrl.j_instruction = 1'b1;
            end
            op_jal: begin
                ctrl.jal_instruction = 1'b1;
                ctrl.alu_op          = alu_add;              // pc + 4 into the link register
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/general_reg.sv
`default_nettype none

module general_reg import id_pkg::*; #(
    parameter int reg_count = 32                    // register file depth
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  reg_idx_t             rd_idx_1,          // rs
    input  reg_idx_t             rd_idx_2,          // rt
    output logic [isa_width-1:0] rd_data_1,
    output logic [isa_width-1:0] rd_data_2,
    input  logic                 wr_en,             // write back valid
    input  reg_idx_t             wr_idx,
    input  logic [isa_width-1:0] wr_data
);

    logic [isa_width-1:0] regs [reg_count];         // entry 0 never written

    function automatic logic [isa_width-1:0] read_port(input reg_idx_t idx);
        if (idx == '0 || int'(idx) >= reg_count) begin
            return '0;                              // x0 and absent entries read zero
        end
        if (wr_en && wr_idx == idx) begin
            return wr_data;                         // write of this cycle wins
        end
        return regs[idx];
    endfunction

    always_comb begin
        rd_data_1 = read_port(rd_idx_1);
        rd_data_2 = read_port(rd_idx_2);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;                      // whole file cleared
            end
        end else if (wr_en && wr_idx != '0 && int'(wr_idx) < reg_count) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// File: hdl/operand_fetch.sv
`default_nettype none

module operand_fetch import id_pkg::*; #(
    parameter int reg_count = 32
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  reg_idx_t             rs_idx,            // instruction[25:21]
    input  reg_idx_t             rt_idx,            // instruction[20:16]
    input  logic [15:0]          immediate,         // instruction[15:0]
    input  logic                 branch_ne,         // opcode bit 0, bne when set
    input  logic                 wb_en,             // from write back stage
    input  reg_idx_t             wb_idx,
    input  logic [isa_width-1:0] wb_data,
    id_operand_if.fetch          operands
);

    logic [isa_width-1:0] rs_value;
    logic [isa_width-1:0] rt_value;

    general_reg #(
        .reg_count (reg_count)
    ) u_general_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_idx_1  (rs_idx),
        .rd_idx_2  (rt_idx),
        .rd_data_1 (rs_value),
        .rd_data_2 (rt_value),
        .wr_en     (wb_en),
        .wr_idx    (wb_idx),
        .wr_data   (wb_data)
    );

    assign operands.reg_1 = rs_value;
    assign operands.reg_2 = rt_value;
    assign operands.sign_extend_result = {{(isa_width - 16){immediate[15]}}, immediate};
    // equality test, inverted for bne
    assign operands.condition_satisfied = branch_ne ? (rs_value != rt_value)
                                                    : (rs_value == rt_value);

endmodule

`default_nettype wire

// File: hdl/signal_mux.sv
`default_nettype none

module signal_mux import id_pkg::*; (
    id_ctrl_if.mux                         ctrl,               // decoded flags
    id_operand_if.mux                      operands,           // register values and immediate
    input  logic                           id_no_op,           // bubble in decode
    input  logic [isa_width-1:0]           id_pc,
    input  logic [isa_width-1:0]           id_instruction,     // source of the jump field
    input  logic [shift_amount_width-1:0]  shift_amount,
    input  reg_idx_t                       id_reg_1_idx,       // rs
    input  reg_idx_t                       id_reg_2_idx,       // rt
    input  reg_idx_t                       id_reg_dest_idx,    // rd
    output logic                           pc_offset,          // branch taken
    output logic                           pc_overload,        // jump taken
    output logic [isa_width-1:0]           pc_overload_value,  // absolute jump target
    output logic [isa_width-1:0]           mux_operand_1,
    output logic [isa_width-1:0]           mux_operand_2,      // immediate, link offset or rt
    output reg_idx_t                       mux_reg_1_idx,
    output reg_idx_t                       mux_reg_2_idx,
    output reg_idx_t                       mux_reg_dest_idx
);

    logic j_type_normal;                                       // j or jal, target from field
    assign j_type_normal = ctrl.j_instruction | ctrl.jal_instruction;

    assign pc_offset   = ~id_no_op & ctrl.branch_instruction & operands.condition_satisfied;
    assign pc_overload = ~id_no_op & (j_type_normal | ctrl.jr_instruction);

    // region bits of pc, word field, byte offset 00
    assign pc_overload_value = j_type_normal ? {id_pc[isa_width-1:address_width+2],
                                                id_instruction[address_width-1:0], 2'b00}
                                             : operands.reg_1;          // jr

    assign mux_operand_1 = ctrl.jal_instruction   ? id_pc :
                           ctrl.shift_instruction ? {{(isa_width - shift_amount_width){1'b0}},
                                                     shift_amount} :
                                                    operands.reg_1;
    assign mux_operand_2 = ctrl.i_type_instruction ? operands.sign_extend_result :
                           ctrl.jal_instruction    ? isa_width'(isa_width / 8) :  // return pc + 4
                                                     operands.reg_2;

    // unused sources go to zero so forwarding sees no dependence
    assign mux_reg_1_idx = (j_type_normal | ctrl.shift_instruction) ? '0 : id_reg_1_idx;
    assign mux_reg_2_idx = (ctrl.r_type_instruction | ctrl.branch_instruction) ? id_reg_2_idx
                                                                               : '0;

    always_comb begin
        if (ctrl.i_type_instruction) begin
            mux_reg_dest_idx = id_reg_2_idx;                   // rt is the target
        end else if (ctrl.branch_instruction | ctrl.jr_instruction) begin
            mux_reg_dest_idx = '0;                             // nothing written
        end else if (ctrl.jal_instruction) begin
            mux_reg_dest_idx = reg_idx_t'(jal_reg_idx);
        end else begin
            mux_reg_dest_idx = id_reg_dest_idx;                // r type rd
        end
    end

endmodule

`default_nettype wire

// File: hdl/id_ex_reg.sv
`default_nettype none

module id_ex_reg import id_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 id_no_op,          // bubble in decode
    input  alu_op_e              alu_op,
    input  logic [isa_width-1:0] mux_operand_1,
    input  logic [isa_width-1:0] mux_operand_2,
    input  reg_idx_t             mux_reg_1_idx,
    input  reg_idx_t             mux_reg_2_idx,
    input  reg_idx_t             mux_reg_dest_idx,
    output logic                 ex_no_op,
    output alu_op_e              ex_alu_op,
    output logic [isa_width-1:0] ex_operand_1,
    output logic [isa_width-1:0] ex_operand_2,
    output reg_idx_t             ex_reg_1_idx,
    output reg_idx_t             ex_reg_2_idx,
    output reg_idx_t             ex_reg_dest_idx
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_no_op        <= 1'b1;                // execute starts on a bubble
            ex_alu_op       <= alu_nop;
            ex_operand_1    <= '0;
            ex_operand_2    <= '0;
            ex_reg_1_idx    <= '0;
            ex_reg_2_idx    <= '0;
            ex_reg_dest_idx <= '0;
        end else begin
            ex_no_op        <= id_no_op;
            ex_alu_op       <= id_no_op ? alu_nop : alu_op;
            ex_operand_1    <= mux_operand_1;
            ex_operand_2    <= mux_operand_2;
            ex_reg_1_idx    <= mux_reg_1_idx;
            ex_reg_2_idx    <= mux_reg_2_idx;
            ex_reg_dest_idx <= id_no_op ? '0 : mux_reg_dest_idx;  // bubble must not write back
        end
    end

endmodule

`default_nettype wire

// File: hdl/id_stage.sv
`default_nettype none

module id_stage import id_pkg::*; #(
    parameter int reg_count = 32                        // register file depth
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [isa_width-1:0] instruction,           // from fetch
    input  logic [isa_width-1:0] pc,
    input  logic                 no_op,                 // instruction is a bubble
    input  logic                 wb_en,                 // write back port
    input  reg_idx_t             wb_idx,
    input  logic [isa_width-1:0] wb_data,
    output logic                 pc_offset,             // to fetch, same cycle
    output logic [isa_width-1:0] pc_offset_value,
    output logic                 pc_overload,
    output logic [isa_width-1:0] pc_overload_value,
    output logic                 ex_no_op,              // to execute, one cycle later
    output alu_op_e              ex_alu_op,
    output logic [isa_width-1:0] ex_operand_1,
    output logic [isa_width-1:0] ex_operand_2,
    output reg_idx_t             ex_reg_1_idx,
    output reg_idx_t             ex_reg_2_idx,
    output reg_idx_t             ex_reg_dest_idx
);

    opcode_e                       id_opcode;            // field slices
    funct_e                        id_funct;
    reg_idx_t                      rs_idx;
    reg_idx_t                      rt_idx;
    reg_idx_t                      rd_idx;
    logic [shift_amount_width-1:0] shamt;
    logic [isa_width-1:0]          mux_operand_1;
    logic [isa_width-1:0]          mux_operand_2;
    reg_idx_t                      mux_reg_1_idx;
    reg_idx_t                      mux_reg_2_idx;
    reg_idx_t                      mux_reg_dest_idx;

    assign id_opcode = opcode_e'(instruction[31:26]);
    assign id_funct  = funct_e'(instruction[5:0]);
    assign rs_idx    = instruction[25:21];
    assign rt_idx    = instruction[20:16];
    assign rd_idx    = instruction[15:11];
    assign shamt     = instruction[10:6];

    id_ctrl_if    ctrl_bus ();
    id_operand_if operand_bus ();

    control_unit u_control_unit (
        .opcode (id_opcode),
        .funct  (id_funct),
        .ctrl   (ctrl_bus.decoder)
    );

    operand_fetch #(
        .reg_count (reg_count)
    ) u_operand_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs_idx    (rs_idx),
        .rt_idx    (rt_idx),
        .immediate (instruction[15:0]),
        .branch_ne (instruction[26]),                    // opcode bit 0
        .wb_en     (wb_en),
        .wb_idx    (wb_idx),
        .wb_data   (wb_data),
        .operands  (operand_bus.fetch)
    );

    signal_mux u_signal_mux (
        .ctrl              (ctrl_bus.mux),
        .operands          (operand_bus.mux),
        .id_no_op          (no_op),
        .id_pc             (pc),
        .id_instruction    (instruction),
        .shift_amount      (shamt),
        .id_reg_1_idx      (rs_idx),
        .id_reg_2_idx      (rt_idx),
        .id_reg_dest_idx   (rd_idx),
        .pc_offset         (pc_offset),
        .pc_overload       (pc_overload),
        .pc_overload_value (pc_overload_value),
        .mux_operand_1     (mux_operand_1),
        .mux_operand_2     (mux_operand_2),
        .mux_reg_1_idx     (mux_reg_1_idx),
        .mux_reg_2_idx     (mux_reg_2_idx),
        .mux_reg_dest_idx  (mux_reg_dest_idx)
    );

    assign pc_offset_value = operand_bus.sign_extend_result;  // sign extended branch offset

    id_ex_reg u_id_ex_reg (
        .clk              (clk),
        .rst_n            (rst_n),
        .id_no_op         (no_op),
        .alu_op           (ctrl_bus.alu_op),
        .mux_operand_1    (mux_operand_1),
        .mux_operand_2    (mux_operand_2),
        .mux_reg_1_idx    (mux_reg_1_idx),
        .mux_reg_2_idx    (mux_reg_2_idx),
        .mux_reg_dest_idx (mux_reg_dest_idx),
        .ex_no_op         (ex_no_op),
        .ex_alu_op        (ex_alu_op),
        .ex_operand_1     (ex_operand_1),
        .ex_operand_2     (ex_operand_2),
        .ex_reg_1_idx     (ex_reg_1_idx),
        .ex_reg_2_idx     (ex_reg_2_idx),
        .ex_reg_dest_idx  (ex_reg_dest_idx)
    );

endmodule

`default_nettype wire

// File: tb/id_stage_asserts.sv
`default_nettype none

module id_stage_asserts import id_pkg::*; (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 no_op,              // bubble in decode
    input logic [isa_width-1:0] instruction,
    input logic                 pc_offset,          // branch taken
    input logic                 pc_overload,        // jump taken
    input logic [isa_width-1:0] pc_overload_value
);

    timeunit 1ns;
    timeprecision 1ps;

    int   failure_count = 0;                        // assertion failures so far
    logic j_or_jal;                                 // target built from the 26 bit field
    assign j_or_jal = (instruction[31:26] == op_j) || (instruction[31:26] == op_jal);

    redirect_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(pc_offset && pc_overload))
        else begin
            failure_count++;
            $error("branch and jump redirect raised together");
        end

    bubble_no_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        no_op |-> (!pc_offset && !pc_overload))
        else begin
            failure_count++;
            $error("redirect raised for a bubble");
        end

    jump_target_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (j_or_jal && !no_op) |-> (pc_overload_value[1:0] == 2'b00))
        else begin
            failure_count++;
            $error("j or jal target not word aligned");
        end

endmodule

bind id_stage id_stage_asserts u_id_stage_asserts (
    .clk               (clk),
    .rst_n             (rst_n),
    .no_op             (no_op),
    .instruction       (instruction),
    .pc_offset         (pc_offset),
    .pc_overload       (pc_overload),
    .pc_overload_value (pc_overload_value)
);

`default_nettype wire

// File: tb/id_stage_tb.sv
`default_nettype none

module id_stage_tb import id_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_instr      = 2000;         // instructions in the run
    localparam int reset_cycles   = 3;
    localparam int directed_reads = 16;           // first instructions sweep all registers
    localparam int cycle_limit    = num_instr + 100;  // reset, drain and slack

    // legal opcodes weighted toward r type, last three are illegal
    localparam logic [5:0] opcode_pool [16] = '{
        op_rtype, op_rtype, op_rtype, op_j, op_jal, op_beq, op_bne, op_addi,
        op_slti, op_andi, op_ori, op_lw, op_sw, 6'h01, 6'h0f, 6'h3f
    };
    // every funct once, common ones again, four illegal codes
    localparam logic [5:0] funct_pool [16] = '{
        fn_sll, fn_srl, fn_jr, fn_add, fn_sub, fn_and, fn_or, fn_slt,
        fn_add, fn_sub, fn_slt, fn_jr, 6'h01, 6'h10, 6'h21, 6'h3f
    };

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic [isa_width-1:0] instruction;
    logic [isa_width-1:0] pc;
    logic                 no_op;
    logic                 wb_en;
    reg_idx_t             wb_idx;
    logic [isa_width-1:0] wb_data;
    logic                 pc_offset;
    logic [isa_width-1:0] pc_offset_value;
    logic                 pc_overload;
    logic [isa_width-1:0] pc_overload_value;
    logic                 ex_no_op;
    alu_op_e              ex_alu_op;
    logic [isa_width-1:0] ex_operand_1;
    logic [isa_width-1:0] ex_operand_2;
    reg_idx_t             ex_reg_1_idx;
    reg_idx_t             ex_reg_2_idx;
    reg_idx_t             ex_reg_dest_idx;

    logic [isa_width-1:0] model_regs [32];        // reference register file
    logic                 exp_no_op;              // registered outputs due next cycle
    alu_op_e              exp_alu_op;
    logic [isa_width-1:0] exp_operand_1;
    logic [isa_width-1:0] exp_operand_2;
    reg_idx_t             exp_reg_1_idx;
    reg_idx_t             exp_reg_2_idx;
    reg_idx_t             exp_reg_dest_idx;
    int                   seed        = 32'h6960_ad15;
    int                   cycle_count = 0;
    int                   check_count = 0;
    int                   error_count = 0;

    always #50 clk = ~clk;                        // 100 ns period

    id_stage #(
        .reg_count (32)
    ) UUT (
        .clk (clk), .rst_n (rst_n), .instruction (instruction), .pc (pc), .no_op (no_op),
        .wb_en (wb_en), .wb_idx (wb_idx), .wb_data (wb_data),
        .pc_offset (pc_offset), .pc_offset_value (pc_offset_value),
        .pc_overload (pc_overload), .pc_overload_value (pc_overload_value),
        .ex_no_op (ex_no_op), .ex_alu_op (ex_alu_op),
        .ex_operand_1 (ex_operand_1), .ex_operand_2 (ex_operand_2),
        .ex_reg_1_idx (ex_reg_1_idx), .ex_reg_2_idx (ex_reg_2_idx),
        .ex_reg_dest_idx (ex_reg_dest_idx)
    );

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run did not complete within %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic check_idx(input string name, input reg_idx_t expected, input reg_idx_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic check_alu_op(input string name, input alu_op_e expected,
                                input alu_op_e actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    // register read as decode sees it, with same cycle write back
    function automatic logic [31:0] model_read(input reg_idx_t idx);
        if (idx == 5'd0) begin
            return '0;
        end
        if (wb_en && wb_idx == idx) begin
            return wb_data;
        end
        return model_regs[idx];
    endfunction

    task automatic drive_instruction(input int n);
        logic [31:0] body;
        logic [31:0] ctl;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] instr;
        body = $random(seed);
        ctl  = $random(seed);
        addr = $random(seed);
        data = $random(seed);
        if (n < directed_reads) begin
            instr = {op_rtype, 5'(2 * n), 5'(2 * n + 1), body[15:11], 5'd0, fn_add};
            no_op <= 1'b0;
            wb_en <= 1'b0;                        // registers must still read their reset value
        end else begin
            instr = {opcode_pool[ctl[3:0]], body[25:0]};
            if (instr[31:26] == op_rtype) begin
                instr[5:0] = funct_pool[ctl[7:4]];
            end
            if ((instr[31:26] == op_beq || instr[31:26] == op_bne) && ctl[9:8] == 2'b00) begin
                instr[20:16] = instr[25:21];      // rs == rt, equal operands
            end
            no_op <= (ctl[12:10] == 3'b000);      // about one in eight
            wb_en <= ctl[13];
        end
        instruction <= instr;
        pc          <= {addr[31:2], 2'b00};
        wb_idx      <= (ctl[15:14] == 2'b00) ? instr[25:21] : ctl[20:16];  // bypass hit on rs
        wb_data     <= data;
    endtask

    // compare last cycle's prediction, then predict the instruction now in decode
    task automatic check_cycle();
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [31:0] v1;
        logic [31:0] v2;
        logic [31:0] imm;
        logic [31:0] op1;
        logic [31:0] op2;
        logic        is_r;
        logic        is_i;
        logic        is_shift;
        logic        is_branch;
        logic        is_j;
        logic        is_jal;
        logic        is_jr;
        logic        jump;
        alu_op_e     alu;
        reg_idx_t    dst;
        check_flag("ex_no_op", exp_no_op, ex_no_op);
        check_alu_op("ex_alu_op", exp_alu_op, ex_alu_op);
        check_word("ex_operand_1", exp_operand_1, ex_operand_1);
        check_word("ex_operand_2", exp_operand_2, ex_operand_2);
        check_idx("ex_reg_1_idx", exp_reg_1_idx, ex_reg_1_idx);
        check_idx("ex_reg_2_idx", exp_reg_2_idx, ex_reg_2_idx);
        check_idx("ex_reg_dest_idx", exp_reg_dest_idx, ex_reg_dest_idx);

        op  = instruction[31:26];
        fn  = instruction[5:0];
        v1  = model_read(instruction[25:21]);     // rs
        v2  = model_read(instruction[20:16]);     // rt
        imm = {{16{instruction[15]}}, instruction[15:0]};
        {is_r, is_i, is_shift, is_branch, is_j, is_jal, is_jr} = '0;
        alu = alu_nop;
        case (op)
            op_rtype: begin
                case (fn)
                    fn_add: alu = alu_add;
                    fn_sub: alu = alu_sub;
                    fn_and: alu = alu_and;
                    fn_or:  alu = alu_or;
                    fn_slt: alu = alu_slt;
                    fn_sll: alu = alu_sll;
                    fn_srl: alu = alu_srl;
                    fn_jr:  is_jr = 1'b1;
                    default: ;
                endcase
                is_shift = (alu == alu_sll) || (alu == alu_srl);
                is_r     = (alu != alu_nop);      // jr and unknown funct excluded
            end
            op_addi, op_lw, op_sw: begin
                is_i = 1'b1;
                alu  = alu_add;
            end
            op_slti: begin
                is_i = 1'b1;
                alu  = alu_slt;
            end
            op_andi: begin
                is_i = 1'b1;
                alu  = alu_and;
            end
            op_ori: begin
                is_i = 1'b1;
                alu  = alu_or;
            end
            op_beq, op_bne: begin
                is_branch = 1'b1;
                alu       = alu_sub;
            end
            op_j:    is_j = 1'b1;
            op_jal: begin
                is_jal = 1'b1;
                alu    = alu_add;
            end
            default: ;                            // illegal opcode decodes to nothing
        endcase

        op1  = is_jal ? pc : (is_shift ? {27'd0, instruction[10:6]} : v1);
        op2  = is_i ? imm : (is_jal ? 32'd4 : v2);
        jump = !no_op && (is_j || is_jal || is_jr);
        check_flag("pc_offset", !no_op && is_branch && (op[0] ? (v1 != v2) : (v1 == v2)),
                   pc_offset);
        check_flag("pc_overload", jump, pc_overload);
        if (jump) begin
            check_word("pc_overload_value",
                       is_jr ? v1 : {pc[31:28], instruction[25:0], 2'b00}, pc_overload_value);
        end
        check_word("pc_offset_value", imm, pc_offset_value);  // branch displacement

        if (is_i) begin
            dst = instruction[20:16];             // rt
        end else if (is_branch || is_jr) begin
            dst = 5'd0;
        end else if (is_jal) begin
            dst = 5'd31;                          // link register
        end else begin
            dst = instruction[15:11];             // rd
        end
        exp_no_op        = no_op;
        exp_alu_op       = no_op ? alu_nop : alu;
        exp_operand_1    = op1;
        exp_operand_2    = op2;
        exp_reg_1_idx    = (is_j || is_jal || is_shift) ? 5'd0 : instruction[25:21];
        exp_reg_2_idx    = (is_r || is_branch) ? instruction[20:16] : 5'd0;
        exp_reg_dest_idx = no_op ? 5'd0 : dst;

        if (wb_en && wb_idx != 5'd0) begin
            model_regs[wb_idx] = wb_data;         // lands on the coming edge
        end
    endtask

    initial begin
        rst_n       <= 1'b0;
        instruction <= '0;
        pc          <= '0;
        no_op       <= 1'b1;
        wb_en       <= 1'b0;
        wb_idx      <= '0;
        wb_data     <= '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        exp_no_op        = 1'b1;                  // execute side right after reset
        exp_alu_op       = alu_nop;
        exp_operand_1    = '0;
        exp_operand_2    = '0;
        exp_reg_1_idx    = '0;
        exp_reg_2_idx    = '0;
        exp_reg_dest_idx = '0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        for (int n = 0; n < num_instr; n++) begin
            @(negedge clk);
            check_cycle();
            @(posedge clk);
            drive_instruction(n);
        end
        @(negedge clk);
        check_cycle();
        @(posedge clk);
        no_op <= 1'b1;                            // drain the last instruction
        wb_en <= 1'b0;
        @(negedge clk);
        check_cycle();
        error_count += UUT.u_id_stage_asserts.failure_count;  // bound assertion failures
        $display("checks run %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
hdl/id_pkg.sv
hdl/id_ctrl_if.sv
hdl/id_operand_if.sv
hdl/control_unit.sv
hdl/general_reg.sv
hdl/operand_fetch.sv
hdl/signal_mux.sv
hdl/id_ex_reg.sv
hdl/id_stage.sv
tb/id_stage_asserts.sv
tb/id_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module id_stage_tb -o id_stage_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/id_stage_sim)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1
